//--- isaPkg.sv
//****************************************
// Instruction set of the 16-bit core
// Word addressed, 256 words, 8 registers
// rt and imm6 share the low six bits
// Opcodes 9 to 15 are illegal
//****************************************
`default_nettype none
package isaPkg;

   localparam int MEM_ADDR_BITS = 8;
   localparam int NUM_REGS = 8;

   typedef logic [15:0] word_t;
   typedef logic [MEM_ADDR_BITS-1:0] memAddr_t;
   typedef logic [2:0] regIdx_t;
   typedef logic signed [5:0] imm6_t;

   typedef enum logic [3:0] {
      OP_NOP  = 4'h0,
      OP_ADD  = 4'h1,
      OP_SUB  = 4'h2,
      OP_AND  = 4'h3,
      OP_ADDI = 4'h4,
      OP_LD   = 4'h5,
      OP_ST   = 4'h6,
      OP_BEQZ = 4'h7,
      OP_HALT = 4'h8
   } opcode_e;

   // rt sits in imm6[5:3]
   typedef struct packed {
      logic [3:0] opcode;
      regIdx_t rd;
      regIdx_t rs;
      imm6_t imm6;
   } instr_t;

endpackage
`default_nettype wire

//--- pipePkg.sv
//****************************************
// Pipeline handoffs and memory bus types
// Tag bit 1 selects the peer, bit 0 is
// the fetch epoch
//****************************************
`default_nettype none
package pipePkg;

   typedef logic [1:0] credit_t;
   typedef logic [1:0] reqTag_t;

   localparam credit_t FETCH_CREDITS = 2'd2;
   localparam credit_t DATA_CREDITS = 2'd1;

   typedef enum logic [1:0] {
      ALU_ADD = 2'd0,
      ALU_SUB = 2'd1,
      ALU_AND = 2'd2
   } aluOp_e;

   typedef struct packed {
      logic valid;
      isaPkg::word_t pc;
      isaPkg::word_t instr;
   } fetchOut_t;

   typedef struct packed {
      logic valid;
      isaPkg::opcode_e opcode;
      aluOp_e aluOp;
      isaPkg::regIdx_t rd;
      isaPkg::word_t opA;
      isaPkg::word_t opB;
      isaPkg::word_t imm;
      isaPkg::word_t pc;
      logic regWrite;
      logic isLoad;
      logic isStore;
      logic isBranch;
      logic isHalt;
   } decodeOut_t;

   typedef struct packed {
      logic valid;
      isaPkg::regIdx_t rd;
      isaPkg::word_t result;
      isaPkg::word_t storeData;
      logic regWrite;
      logic isLoad;
      logic isStore;
      logic isHalt;
   } execOut_t;

   typedef struct packed {
      logic valid;
      isaPkg::regIdx_t rd;
      isaPkg::word_t data;
      logic regWrite;
      logic isHalt;
   } wbOut_t;

   typedef struct packed {
      logic valid;
      logic regWrite;
      isaPkg::regIdx_t rd;
   } regBusy_t;

   typedef struct packed {
      logic valid;
      isaPkg::word_t target;
   } redirect_t;

   typedef struct packed {
      logic valid;
      logic write;
      isaPkg::memAddr_t addr;
      isaPkg::word_t wdata;
      reqTag_t tag;
   } memReq_t;

   typedef struct packed {
      logic valid;
      isaPkg::word_t rdata;
      reqTag_t tag;
   } memResp_t;

endpackage
`default_nettype wire

//--- unifiedMem.sv
//****************************************
// 256-word RAM, read data one cycle on
// Every request gets a response
// Boot writes win over the bus
//****************************************
`timescale 1ns/100ps
`default_nettype none
module unifiedMem (
   input wire logic clk,
   input wire pipePkg::memReq_t memReq,
   input wire logic bootEn,
   input wire isaPkg::memAddr_t bootAddr,
   input wire isaPkg::word_t bootData,
   output pipePkg::memResp_t memResp
);
   import isaPkg::*;
   import pipePkg::*;

   word_t mem [2**MEM_ADDR_BITS];

   always_ff @(posedge clk) begin
      if (bootEn)
         mem[bootAddr] <= bootData;
      else if (memReq.valid && memReq.write)
         mem[memReq.addr] <= memReq.wdata;
      memResp.valid <= memReq.valid;
      memResp.rdata <= mem[memReq.addr];
      memResp.tag <= memReq.tag;
   end

endmodule
`default_nettype wire

//--- memArbiter.sv
//****************************************
// Fixed priority, data before fetch
// Responses steered by tag bit 1
//****************************************
`timescale 1ns/100ps
`default_nettype none
module memArbiter (
   input wire pipePkg::memReq_t fetchReq,
   input wire pipePkg::memReq_t dataReq,
   input wire pipePkg::memResp_t memResp,
   output logic fetchGrant,
   output logic dataGrant,
   output pipePkg::memReq_t memReq,
   output pipePkg::memResp_t fetchResp,
   output pipePkg::memResp_t dataResp
);
   import pipePkg::*;

   always_comb begin
      dataGrant = dataReq.valid;
      fetchGrant = fetchReq.valid && !dataReq.valid;
      memReq = dataReq.valid ? dataReq : fetchReq;

      fetchResp = memResp;
      fetchResp.valid = memResp.valid && !memResp.tag[1];
      dataResp = memResp;
      dataResp.valid = memResp.valid && memResp.tag[1];
   end

endmodule
`default_nettype wire

//--- fetchStage.sv
//****************************************
// Fetch with two credits and a two-entry
// buffer; responses return in order
// Old-epoch responses are dropped
//****************************************
`timescale 1ns/100ps
`default_nettype none
module fetchStage (
   input wire logic clk,
   input wire logic rstN,
   input wire pipePkg::redirect_t redirect,
   input wire logic stall,
   input wire logic stop,
   input wire logic fetchGrant,
   input wire pipePkg::memResp_t fetchResp,
   output pipePkg::memReq_t fetchReq,
   output pipePkg::fetchOut_t fetchOut
);
   import isaPkg::*;
   import pipePkg::*;

   credit_t credits;
   word_t pc;
   logic epoch;
   word_t entryPc [2];
   word_t entryInstr [2];
   logic [1:0] allocCnt;
   logic [1:0] fillCnt;
   logic head;
   logic issue;
   logic respOk;
   logic fill;
   logic pop;
   logic allocIdx;
   logic fillIdx;

   always_comb begin
      fetchReq.valid = !stop && credits != 2'd0 && allocCnt != 2'd2;
      fetchReq.write = 1'b0;
      fetchReq.addr = pc[MEM_ADDR_BITS-1:0];
      fetchReq.wdata = '0;
      fetchReq.tag = {1'b0, epoch};
      issue = fetchReq.valid && fetchGrant;
      // A response with nothing outstanding is a leftover from reset
      respOk = fetchResp.valid && credits != FETCH_CREDITS;
      fill = respOk && fetchResp.tag[0] == epoch && !redirect.valid;
      fetchOut.valid = fillCnt != 2'd0;
      fetchOut.pc = entryPc[head];
      fetchOut.instr = entryInstr[head];
      pop = fetchOut.valid && !stall && !redirect.valid;
      allocIdx = head ^ allocCnt[0];
      fillIdx = head ^ fillCnt[0];
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         credits <= FETCH_CREDITS;
         pc <= '0;
         epoch <= 1'b0;
         allocCnt <= 2'd0;
         fillCnt <= 2'd0;
         head <= 1'b0;
      end else begin
         credits <= credits - credit_t'(issue) + credit_t'(respOk);
         if (redirect.valid) begin
            pc <= redirect.target;
            epoch <= ~epoch;
            allocCnt <= 2'd0;
            fillCnt <= 2'd0;
         end else begin
            if (issue)
               pc <= pc + 16'd1;
            allocCnt <= allocCnt + 2'(issue) - 2'(pop);
            fillCnt <= fillCnt + 2'(fill) - 2'(pop);
            head <= head ^ pop;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (issue && !redirect.valid)
         entryPc[allocIdx] <= pc;
      if (fill)
         entryInstr[fillIdx] <= fetchResp.rdata;
   end

endmodule
`default_nettype wire

//--- decodeStage.sv
//****************************************
// Decode, register file and interlock
// No forwarding; RAW against X, M and W
// stalls until writeback is done
//****************************************
`timescale 1ns/100ps
`default_nettype none
module decodeStage (
   input wire logic clk,
   input wire logic rstN,
   input wire pipePkg::fetchOut_t fetchOut,
   input wire logic flush,
   input wire logic stall,
   input wire pipePkg::regBusy_t execBusy,
   input wire pipePkg::regBusy_t memBusy,
   input wire pipePkg::regBusy_t wbBusy,
   input wire pipePkg::wbOut_t wbOut,
   output pipePkg::decodeOut_t decodeOut,
   output logic hazardStall,
   output logic haltSeen,
   output logic illegal
);
   import isaPkg::*;
   import pipePkg::*;

   word_t regs [NUM_REGS];
   instr_t ins;
   decodeOut_t next;
   regIdx_t srcA;
   regIdx_t srcB;
   logic useA;
   logic useB;
   logic legal;
   logic raw;
   logic accept;

   function automatic logic busyOn(regBusy_t b, regIdx_t r);
      return b.valid && b.regWrite && b.rd == r;
   endfunction

   // Same-cycle writeback is visible to the read
   function automatic word_t readReg(regIdx_t r);
      if (wbOut.valid && wbOut.regWrite && wbOut.rd == r)
         return wbOut.data;
      return regs[r];
   endfunction

   always_comb begin
      ins = instr_t'(fetchOut.instr);
      next = '0;
      next.opcode = opcode_e'(ins.opcode);
      next.rd = ins.rd;
      next.pc = fetchOut.pc;
      next.imm = {{10{ins.imm6[5]}}, ins.imm6};
      next.aluOp = ALU_ADD;
      srcA = ins.rs;
      srcB = ins.imm6[5:3];
      useA = 1'b0;
      useB = 1'b0;
      legal = 1'b1;
      case (ins.opcode)
         OP_NOP: ;
         OP_ADD, OP_SUB, OP_AND: begin
            useA = 1'b1;
            useB = 1'b1;
            next.regWrite = 1'b1;
            next.aluOp = ins.opcode == OP_SUB ? ALU_SUB :
                         ins.opcode == OP_AND ? ALU_AND : ALU_ADD;
         end
         OP_ADDI, OP_LD: begin
            useA = 1'b1;
            next.regWrite = 1'b1;
            next.isLoad = ins.opcode == OP_LD;
         end
         OP_ST: begin
            useA = 1'b1;
            useB = 1'b1;
            srcB = ins.rd;
            next.isStore = 1'b1;
         end
         OP_BEQZ: begin
            useA = 1'b1;
            srcA = ins.rd;
            next.isBranch = 1'b1;
         end
         OP_HALT: next.isHalt = 1'b1;
         default: legal = 1'b0;
      endcase
      next.opA = readReg(srcA);
      next.opB = readReg(srcB);
      raw = (useA && (busyOn(execBusy, srcA) || busyOn(memBusy, srcA) ||
                      busyOn(wbBusy, srcA))) ||
            (useB && (busyOn(execBusy, srcB) || busyOn(memBusy, srcB) ||
                      busyOn(wbBusy, srcB)));
      hazardStall = fetchOut.valid && legal && raw;
      accept = fetchOut.valid && !stall && !flush && !hazardStall;
      haltSeen = accept && ins.opcode == OP_HALT;
      illegal = accept && !legal;
      next.valid = accept && legal;
   end

   always_ff @(posedge clk) begin
      if (!rstN)
         decodeOut <= '0;
      else if (!stall)
         decodeOut <= next;
   end

   always_ff @(posedge clk) begin
      if (wbOut.valid && wbOut.regWrite)
         regs[wbOut.rd] <= wbOut.data;
   end

endmodule
`default_nettype wire

//--- executeStage.sv
//****************************************
// ALU, address generation and BEQZ
// Redirect is combinational, held off
// while memory stalls the stage
//****************************************
`timescale 1ns/100ps
`default_nettype none
module executeStage (
   input wire logic clk,
   input wire logic rstN,
   input wire pipePkg::decodeOut_t decodeOut,
   input wire logic stall,
   output pipePkg::execOut_t execOut,
   output pipePkg::redirect_t redirect
);
   import isaPkg::*;
   import pipePkg::*;

   word_t opB;
   word_t result;
   logic useImm;

   always_comb begin
      useImm = decodeOut.opcode inside {OP_ADDI, OP_LD, OP_ST};
      opB = useImm ? decodeOut.imm : decodeOut.opB;
      case (decodeOut.aluOp)
         ALU_SUB: result = decodeOut.opA - opB;
         ALU_AND: result = decodeOut.opA & opB;
         default: result = decodeOut.opA + opB;
      endcase
      redirect.valid = decodeOut.valid && decodeOut.isBranch && !stall &&
                       decodeOut.opA == '0;
      redirect.target = decodeOut.pc + 16'd1 + decodeOut.imm;
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         execOut <= '0;
      end else if (!stall) begin
         execOut.valid <= decodeOut.valid;
         execOut.rd <= decodeOut.rd;
         execOut.result <= result;
         execOut.storeData <= decodeOut.opB;
         execOut.regWrite <= decodeOut.regWrite;
         execOut.isLoad <= decodeOut.isLoad;
         execOut.isStore <= decodeOut.isStore;
         execOut.isHalt <= decodeOut.isHalt;
      end
   end

endmodule
`default_nettype wire

//--- memStage.sv
//****************************************
// Data access with one credit
// Loads and stores stall until the
// response returns, stores included
//****************************************
`timescale 1ns/100ps
`default_nettype none
module memStage (
   input wire logic clk,
   input wire logic rstN,
   input wire pipePkg::execOut_t execOut,
   input wire logic dataGrant,
   input wire pipePkg::memResp_t dataResp,
   output pipePkg::memReq_t dataReq,
   output pipePkg::wbOut_t wbOut,
   output logic memStall
);
   import isaPkg::*;
   import pipePkg::*;

   credit_t credits;
   logic reqSent;
   logic memOp;
   logic issue;

   always_comb begin
      memOp = execOut.valid && (execOut.isLoad || execOut.isStore);
      dataReq.valid = memOp && !reqSent && credits != 2'd0;
      dataReq.write = execOut.isStore;
      dataReq.addr = execOut.result[MEM_ADDR_BITS-1:0];
      dataReq.wdata = execOut.storeData;
      dataReq.tag = 2'b10;
      issue = dataReq.valid && dataGrant;
      memStall = memOp && !dataResp.valid;
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         credits <= DATA_CREDITS;
         reqSent <= 1'b0;
         wbOut <= '0;
      end else begin
         credits <= credits - credit_t'(issue) + credit_t'(dataResp.valid);
         if (issue)
            reqSent <= 1'b1;
         else if (dataResp.valid)
            reqSent <= 1'b0;
         wbOut.valid <= execOut.valid && !memStall;
         wbOut.rd <= execOut.rd;
         wbOut.data <= execOut.isLoad ? dataResp.rdata : execOut.result;
         wbOut.regWrite <= execOut.regWrite;
         wbOut.isHalt <= execOut.isHalt;
      end
   end

endmodule
`default_nettype wire

//--- procTop.sv
//****************************************
// Five-stage core with unified memory
// Load the program while rstN is low
// halt and err are sticky until reset
//****************************************
`timescale 1ns/100ps
`default_nettype none
module procTop (
   input wire logic clk,
   input wire logic rstN,
   input wire logic bootEn,
   input wire isaPkg::memAddr_t bootAddr,
   input wire isaPkg::word_t bootData,
   output logic err,
   output logic halt,
   output pipePkg::wbOut_t wbTrace
);
   import pipePkg::*;

   memReq_t fetchReq;
   memReq_t dataReq;
   memReq_t memReq;
   memResp_t memResp;
   memResp_t fetchResp;
   memResp_t dataResp;
   fetchOut_t fetchOut;
   decodeOut_t decodeOut;
   execOut_t execOut;
   wbOut_t wbOut;
   redirect_t redirect;
   logic fetchGrant;
   logic dataGrant;
   logic hazardStall;
   logic memStall;
   logic haltSeen;
   logic illegal;
   logic stopReg;
   logic errReg;
   logic haltReg;
   logic stop;

   assign stop = stopReg || haltSeen || illegal;
   assign err = errReg || illegal;
   assign halt = haltReg || (wbOut.valid && wbOut.isHalt);
   assign wbTrace = wbOut;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         stopReg <= 1'b0;
         errReg <= 1'b0;
         haltReg <= 1'b0;
      end else begin
         stopReg <= stop;
         errReg <= err;
         haltReg <= halt;
      end
   end

   fetchStage fetchStage_i (.clk(clk), .rstN(rstN), .redirect(redirect),
      .stall(hazardStall || memStall), .stop(stop), .fetchGrant(fetchGrant),
      .fetchResp(fetchResp), .fetchReq(fetchReq), .fetchOut(fetchOut));

   decodeStage decodeStage_i (.clk(clk), .rstN(rstN), .fetchOut(fetchOut),
      .flush(redirect.valid || stopReg), .stall(memStall),
      .execBusy({decodeOut.valid, decodeOut.regWrite, decodeOut.rd}),
      .memBusy({execOut.valid, execOut.regWrite, execOut.rd}),
      .wbBusy({wbOut.valid, wbOut.regWrite, wbOut.rd}),
      .wbOut(wbOut), .decodeOut(decodeOut), .hazardStall(hazardStall),
      .haltSeen(haltSeen), .illegal(illegal));

   executeStage executeStage_i (.clk(clk), .rstN(rstN), .decodeOut(decodeOut),
      .stall(memStall), .execOut(execOut), .redirect(redirect));

   memStage memStage_i (.clk(clk), .rstN(rstN), .execOut(execOut),
      .dataGrant(dataGrant), .dataResp(dataResp), .dataReq(dataReq),
      .wbOut(wbOut), .memStall(memStall));

   memArbiter memArbiter_i (.fetchReq(fetchReq), .dataReq(dataReq),
      .memResp(memResp), .fetchGrant(fetchGrant), .dataGrant(dataGrant),
      .memReq(memReq), .fetchResp(fetchResp), .dataResp(dataResp));

   unifiedMem unifiedMem_i (.clk(clk), .memReq(memReq), .bootEn(bootEn),
      .bootAddr(bootAddr), .bootData(bootData), .memResp(memResp));

endmodule
`default_nettype wire

//--- tbProc.sv
//****************************************
// Testbench for procTop with eight tests
// Reset covers the boot load plus 8 cycles
// Programs zero all registers first
// Data words live at 0xE0 to 0xFF
//****************************************
`timescale 1ns/100ps
`default_nettype none
module tbProc;
   import isaPkg::*;
   import pipePkg::*;

   localparam int NUM_TESTS = 8;
   localparam int CYCLE_LIMIT = 400 * NUM_TESTS;
   localparam int RESET_CYCLES = 8;
   localparam int DRAIN_CYCLES = 16;
   localparam int DATA_BASE = 224;
   localparam int RANDOM_BODY = 40;

   typedef struct packed {
      regIdx_t rd;
      word_t data;
   } expWrite_t;

   logic clk;
   logic rstN;
   logic bootEn;
   memAddr_t bootAddr;
   word_t bootData;
   logic err;
   logic halt;
   wbOut_t wbTrace;

   word_t prog [$];
   expWrite_t expQ [$];
   expWrite_t expHead;
   word_t modelMem [256];
   word_t modelRegs [NUM_REGS];
   logic expHalt;
   logic expErr;
   logic sawHalt;
   logic sawErr;
   logic [31:0] lcgState;
   int cycleCnt;
   int checkErrors;
   int writesChecked;
   int testNum;
   int testsPassed;
   int testsFailed;
   string testName;

   procTop procTop_i (.clk(clk), .rstN(rstN), .bootEn(bootEn), .bootAddr(bootAddr),
      .bootData(bootData), .err(err), .halt(halt), .wbTrace(wbTrace));

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic [31:0] nextRand();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   function automatic word_t rInstr(opcode_e op, int rd, int rs, int rt);
      return {op, 3'(rd), 3'(rs), 3'(rt), 3'b000};
   endfunction

   function automatic word_t iInstr(opcode_e op, int rd, int rs, int imm);
      return {op, 3'(rd), 3'(rs), 6'(imm)};
   endfunction

   // Data word from the full 8-bit address
   function automatic word_t dataFill(int addr);
      return {8'(addr) ^ 8'h5a, 8'(addr)};
   endfunction

   task automatic logMismatch(input string msg);
      $display("CHECK FAILED at time %0t: %s", $time, msg);
      checkErrors++;
   endtask

   task automatic modelWrite(input logic [2:0] rd, input word_t value);
      expWrite_t w;
      w.rd = rd;
      w.data = value;
      modelRegs[rd] = value;
      expQ.push_back(w);
   endtask

   // ISA reference model that runs the booted image until HALT or a bad opcode
   task automatic runModel();
      word_t pc;
      word_t ins;
      word_t imm;
      word_t offsetSum;
      logic [2:0] rd;
      logic [2:0] rs;
      logic [2:0] rt;
      int steps;
      logic done;
      expQ.delete();
      expHalt = 1'b0;
      expErr = 1'b0;
      pc = '0;
      steps = 0;
      done = 1'b0;
      while (!done && steps < 1000) begin
         ins = modelMem[pc[7:0]];
         rd = ins[11:9];
         rs = ins[8:6];
         rt = ins[5:3];
         imm = {{10{ins[5]}}, ins[5:0]};
         offsetSum = modelRegs[rs] + imm;
         pc = pc + 16'd1;
         steps++;
         case (ins[15:12])
            OP_NOP: ;
            OP_ADD: modelWrite(rd, modelRegs[rs] + modelRegs[rt]);
            OP_SUB: modelWrite(rd, modelRegs[rs] - modelRegs[rt]);
            OP_AND: modelWrite(rd, modelRegs[rs] & modelRegs[rt]);
            OP_ADDI: modelWrite(rd, offsetSum);
            OP_LD: modelWrite(rd, modelMem[offsetSum[7:0]]);
            OP_ST: modelMem[offsetSum[7:0]] = modelRegs[rd];
            OP_BEQZ: begin
               if (modelRegs[rd] == '0)
                  pc = pc + imm;
            end
            OP_HALT: begin
               expHalt = 1'b1;
               done = 1'b1;
            end
            default: begin
               expErr = 1'b1;
               done = 1'b1;
            end
         endcase
      end
   endtask

   task automatic checkTraceWrite();
      assert (!halt) else
         logMismatch($sformatf("r%0d written back after halt", wbTrace.rd));
      assert (expQ.size() != 0) else
         logMismatch($sformatf("unexpected write r%0d = %h", wbTrace.rd, wbTrace.data));
      if (expQ.size() != 0) begin
         expHead = expQ.pop_front();
         writesChecked++;
         assert (wbTrace.rd == expHead.rd && wbTrace.data == expHead.data) else
            logMismatch($sformatf("write r%0d = %h, expected r%0d = %h",
               wbTrace.rd, wbTrace.data, expHead.rd, expHead.data));
      end
   endtask

   // Trace monitor samples away from the driving edge
   always @(negedge clk) begin
      if (!rstN) begin
         sawHalt = 1'b0;
         sawErr = 1'b0;
      end else begin
         if (sawHalt)
            assert (halt) else logMismatch("halt fell after it was raised");
         if (sawErr)
            assert (err) else logMismatch("err fell after it was raised");
         if (wbTrace.valid && wbTrace.regWrite)
            checkTraceWrite();
         if (wbTrace.valid && wbTrace.isHalt) begin
            assert (halt) else logMismatch("halt stayed low with HALT in writeback");
            assert (expQ.size() == 0) else
               logMismatch($sformatf("HALT wrote back with %0d earlier writes missing",
                  expQ.size()));
         end else if (!sawHalt) begin
            assert (!halt) else logMismatch("halt rose before a HALT reached writeback");
         end
         sawHalt = sawHalt || halt;
         sawErr = sawErr || err;
      end
   end

   task automatic bootWord(input int addr, input word_t data);
      @(posedge clk);
      bootEn <= 1'b1;
      bootAddr <= 8'(addr);
      bootData <= data;
   endtask

   task automatic bootProgram();
      foreach (prog[i])
         bootWord(i, prog[i]);
      for (int a = DATA_BASE; a < 256; a++)
         bootWord(a, dataFill(a));
      @(posedge clk);
      bootEn <= 1'b0;
      repeat (RESET_CYCLES - 1) @(posedge clk);
      rstN <= 1'b1;
   endtask

   task automatic runTest(input string name);
      int errorsBefore;
      @(posedge clk);
      rstN <= 1'b0;
      testNum++;
      testName = name;
      errorsBefore = checkErrors;
      writesChecked = 0;
      foreach (prog[i])
         modelMem[i] = prog[i];
      for (int a = DATA_BASE; a < 256; a++)
         modelMem[a] = dataFill(a);
      runModel();
      bootProgram();
      @(posedge clk);
      while (!(sawHalt || sawErr))
         @(posedge clk);
      // Late writes would show up in this window
      repeat (DRAIN_CYCLES) @(posedge clk);
      assert (sawHalt == expHalt) else
         logMismatch($sformatf("halt is %b, expected %b", sawHalt, expHalt));
      assert (sawErr == expErr) else
         logMismatch($sformatf("err is %b, expected %b", sawErr, expErr));
      assert (expQ.size() == 0) else
         logMismatch($sformatf("%0d expected writes never appeared", expQ.size()));
      if (checkErrors == errorsBefore)
         testsPassed++;
      else
         testsFailed++;
      $display("Test %0d, %s: %s, %0d writes checked", testNum, name,
         (checkErrors == errorsBefore) ? "passed" : "FAILED", writesChecked);
   endtask

   task automatic zeroRegs();
      prog.delete();
      for (int r = 0; r < NUM_REGS; r++)
         prog.push_back(rInstr(OP_SUB, r, r, r));
   endtask

   task automatic progAlu();
      zeroRegs();
      prog.push_back(iInstr(OP_ADDI, 1, 0, 5));
      prog.push_back(iInstr(OP_ADDI, 2, 0, -3));
      prog.push_back(iInstr(OP_ADDI, 3, 0, 12));
      prog.push_back(iInstr(OP_ADDI, 4, 0, 9));
      prog.push_back(rInstr(OP_ADD, 5, 1, 2));
      prog.push_back(rInstr(OP_SUB, 6, 3, 4));
      prog.push_back(rInstr(OP_AND, 7, 3, 4));
      prog.push_back(rInstr(OP_HALT, 0, 0, 0));
   endtask

   task automatic progRawChain();
      zeroRegs();
      prog.push_back(iInstr(OP_ADDI, 1, 0, 7));
      prog.push_back(rInstr(OP_ADD, 2, 1, 1));
      prog.push_back(rInstr(OP_SUB, 3, 2, 1));
      prog.push_back(iInstr(OP_ADDI, 3, 3, -2));
      prog.push_back(iInstr(OP_ST, 3, 0, -4));
      prog.push_back(iInstr(OP_LD, 4, 0, -4));
      prog.push_back(rInstr(OP_ADD, 5, 4, 3));
      prog.push_back(rInstr(OP_AND, 6, 5, 2));
      prog.push_back(iInstr(OP_LD, 7, 0, -32));
      prog.push_back(rInstr(OP_ADD, 1, 7, 6));
      prog.push_back(rInstr(OP_HALT, 0, 0, 0));
   endtask

   // Words 20 and 21 sit right after the HALT at word 19
   task automatic progStoreLoad();
      zeroRegs();
      prog.push_back(iInstr(OP_ADDI, 1, 0, 21));
      prog.push_back(iInstr(OP_ADDI, 2, 0, -11));
      prog.push_back(iInstr(OP_ST, 1, 0, -8));
      prog.push_back(iInstr(OP_LD, 3, 0, -8));
      prog.push_back(iInstr(OP_ST, 2, 0, -8));
      prog.push_back(iInstr(OP_LD, 4, 0, -8));
      prog.push_back(iInstr(OP_ST, 3, 0, 20));
      prog.push_back(iInstr(OP_ST, 4, 0, 21));
      prog.push_back(iInstr(OP_LD, 5, 0, 20));
      prog.push_back(iInstr(OP_LD, 6, 0, 21));
      prog.push_back(rInstr(OP_SUB, 7, 5, 6));
      prog.push_back(rInstr(OP_HALT, 0, 0, 0));
   endtask

   task automatic progBranch();
      zeroRegs();
      prog.push_back(iInstr(OP_ADDI, 1, 0, 3));
      prog.push_back(iInstr(OP_BEQZ, 1, 0, 2));
      prog.push_back(iInstr(OP_ADDI, 2, 0, 4));
      prog.push_back(iInstr(OP_BEQZ, 0, 0, 2));
      prog.push_back(iInstr(OP_ADDI, 3, 0, 9));
      prog.push_back(iInstr(OP_ADDI, 4, 0, 9));
      prog.push_back(iInstr(OP_ADDI, 5, 0, 6));
      // Countdown loop of two passes
      prog.push_back(iInstr(OP_ADDI, 6, 0, 2));
      prog.push_back(iInstr(OP_ADDI, 6, 6, -1));
      prog.push_back(iInstr(OP_BEQZ, 6, 0, 1));
      prog.push_back(iInstr(OP_BEQZ, 0, 0, -3));
      prog.push_back(rInstr(OP_ADD, 7, 5, 2));
      prog.push_back(rInstr(OP_HALT, 0, 0, 0));
   endtask

   task automatic progHalt();
      zeroRegs();
      prog.push_back(iInstr(OP_ADDI, 1, 0, 1));
      prog.push_back(iInstr(OP_ADDI, 2, 0, 2));
      prog.push_back(rInstr(OP_HALT, 0, 0, 0));
      prog.push_back(iInstr(OP_ADDI, 3, 0, 3));
      prog.push_back(iInstr(OP_ADDI, 4, 0, 4));
   endtask

   task automatic progIllegal();
      zeroRegs();
      prog.push_back(iInstr(OP_ADDI, 1, 0, 5));
      prog.push_back(rInstr(OP_ADD, 2, 1, 1));
      prog.push_back(16'hf000);
      prog.push_back(iInstr(OP_ADDI, 3, 0, 1));
      prog.push_back(rInstr(OP_HALT, 0, 0, 0));
   endtask

   // r7 stays zero as the base, so LD and ST reach 0xE0 to 0xFF
   task automatic progRandom();
      logic [31:0] r;
      int kind;
      int dst;
      int srcA;
      int srcB;
      int memOff;
      zeroRegs();
      for (int i = 0; i < RANDOM_BODY; i++) begin
         r = nextRand();
         kind = int'(r[31:24]) % 6;
         dst = int'(r[23:16]) % 7;
         srcA = int'(r[15:13]);
         srcB = int'(r[12:10]);
         memOff = int'(r[9:5]) - 32;
         case (kind)
            0: prog.push_back(rInstr(OP_ADD, dst, srcA, srcB));
            1: prog.push_back(rInstr(OP_SUB, dst, srcA, srcB));
            2: prog.push_back(rInstr(OP_AND, dst, srcA, srcB));
            3: prog.push_back(iInstr(OP_ADDI, dst, srcA, int'(r[9:4])));
            4: prog.push_back(iInstr(OP_LD, dst, 7, memOff));
            default: prog.push_back(iInstr(OP_ST, srcA, 7, memOff));
         endcase
      end
      prog.push_back(rInstr(OP_HALT, 0, 0, 0));
   endtask

   initial begin
      cycleCnt = 0;
      while (cycleCnt < CYCLE_LIMIT) begin
         @(posedge clk);
         cycleCnt++;
      end
      $display("Timeout: test %0d (%s) was still running after %0d cycles",
         testNum, testName, cycleCnt);
      $display("Simulation failed");
      $finish;
   end

   initial begin
      rstN = 1'b0;
      bootEn = 1'b0;
      bootAddr = '0;
      bootData = '0;
      lcgState = 32'h595f_875f;
      checkErrors = 0;
      writesChecked = 0;
      testNum = 0;
      testsPassed = 0;
      testsFailed = 0;
      testName = "none";
      sawHalt = 1'b0;
      sawErr = 1'b0;
      progAlu();
      runTest("independent ALU ops");
      progRawChain();
      runTest("RAW chains through a load");
      progStoreLoad();
      runTest("store then load");
      progBranch();
      runTest("taken and untaken BEQZ");
      progHalt();
      runTest("HALT stops writeback");
      progIllegal();
      runTest("illegal opcode");
      progRandom();
      runTest("random program A");
      progRandom();
      runTest("random program B");
      $display("Tests run %0d, passed %0d, failed %0d, failed checks %0d",
         testNum, testsPassed, testsFailed, checkErrors);
      if (testsFailed == 0 && checkErrors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule
`default_nettype wire

//--- filelist.f
isaPkg.sv
pipePkg.sv
unifiedMem.sv
memArbiter.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memStage.sv
procTop.sv
tbProc.sv

//--- runSim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module tbProc -o tbProc \
   && ./obj_dir/tbProc | tee sim.log \
   || { echo "Build or run of tbProc did not complete"; exit 1; }

grep -q "Simulation completed successfully" sim.log \
   && echo "PASS" \
   || { echo "FAIL"; exit 1; }
